//--- tb.f
+incdir+include
rtl/conv_pkg.sv
rtl/tile_scanner.sv
rtl/input_window.sv
rtl/weight_window.sv
rtl/window_mac.sv
rtl/conv_tile_top.sv
bench/conv_tile_tb.sv

//--- Bender.yml
package:
  name: conv_tile

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/conv_pkg.sv
      - rtl/tile_scanner.sv
      - rtl/input_window.sv
      - rtl/weight_window.sv
      - rtl/window_mac.sv
      - rtl/conv_tile_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/conv_tile_tb.sv

//--- bench/conv_tile_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module conv_tile_tb;
	import conv_pkg::*;

	localparam int NUM_TILES = 5;
	localparam int LATENCY = 3;

	logic clk;
	logic rst;
	logic run;
	coord_t map_rows;
	coord_t map_cols;
	logic [`CONV_KSEL_W-1:0] kernel_sel;
	logic in_rd;
	coord_t in_row [3];
	word_addr_t in_word;
	row_word_t in_rdata [3];
	logic w_rd;
	logic [`CONV_KSEL_W-1:0] w_addr;
	tap_word_t w_rdata;
	logic out_valid;
	out_addr_t out_addr;
	acc_t out_data;
	logic tile_done;

	pixel_t img [`CONV_MAP_MAX][`CONV_MAP_MAX];
	tap_t kern [1<<`CONV_KSEL_W][9];
	logic [31:0] rng_state;
	int tile_rows [NUM_TILES];
	int tile_cols [NUM_TILES];
	int tile_ksel [NUM_TILES];
	int errors;
	int cycles;
	int limit;
	int rd_col;
	int rd_at;
	int exp_wd;

	// expected results and read columns in issue order
	acc_t exp_data [$];
	out_addr_t exp_addr [$];
	int exp_col [$];
	int rd_cycle [$];

	// requests seen on one falling edge are answered on the next
	logic rd_pend;
	coord_t pend_row [3];
	word_addr_t pend_word;
	logic w_pend;
	logic [`CONV_KSEL_W-1:0] pend_waddr;

	conv_tile_top dut_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.map_rows(map_rows),
		.map_cols(map_cols),
		.kernel_sel(kernel_sel),
		.in_rd(in_rd),
		.in_row(in_row),
		.in_word(in_word),
		.in_rdata(in_rdata),
		.w_rd(w_rd),
		.w_addr(w_addr),
		.w_rdata(w_rdata),
		.out_valid(out_valid),
		.out_addr(out_addr),
		.out_data(out_data),
		.tile_done(tile_done)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// lane k of word w holds column 4w+k
	// columns past the map array read as zero
	function automatic row_word_t row_word(input coord_t r, input word_addr_t w);
		row_word_t word;
		int c;
		word = '0;
		for (int k = 0; k < `CONV_LANES; k++)
		begin
			c = `CONV_LANES * int'(w) + k;
			if (int'(r) < `CONV_MAP_MAX && c < `CONV_MAP_MAX)
				word[k*`CONV_PIX_W +: `CONV_PIX_W] = img[r][c];
		end
		return word;
	endfunction

	// tap 0 goes to the top slice
	function automatic tap_word_t tap_word(input int sel);
		tap_word_t word;
		word = '0;
		for (int i = 0; i < 9; i++)
			word[(8-i)*`CONV_TAP_W +: `CONV_TAP_W] = kern[sel][i];
		return word;
	endfunction

	task automatic check_out_data(input acc_t exp, input acc_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t out_data: expected %0d got %0d", $time, exp, act);
			errors++;
		end
	endtask

	task automatic check_out_addr(input out_addr_t exp, input out_addr_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t out_addr: expected %0d got %0d", $time, exp, act);
			errors++;
		end
	endtask

	task automatic check_word(input word_addr_t exp, input word_addr_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t in_word: expected %0d got %0d", $time, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] %0t %s: expected %b got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	// plain 3x3 convolution over every valid origin in row-major order
	task automatic expect_tile(input int rows, input int cols, input int sel);
		longint sum;
		for (int r = 0; r <= rows - 3; r++)
			for (int c = 0; c <= cols - 3; c++)
			begin
				sum = 0;
				for (int dy = 0; dy < 3; dy++)
					for (int dx = 0; dx < 3; dx++)
						sum += longint'(img[r+dy][c+dx]) * longint'(kern[sel][3*dy+dx]);
				exp_data.push_back(acc_t'(sum));
				exp_addr.push_back(out_addr_t'(r * (cols - 2) + c));
				exp_col.push_back(c);
			end
	endtask

	task automatic run_tile(input int rows, input int cols, input int sel);
		for (int r = 0; r < `CONV_MAP_MAX; r++)
			for (int c = 0; c < `CONV_MAP_MAX; c++)
				img[r][c] = pixel_t'(xorshift32());
		map_rows = coord_t'(rows);
		map_cols = coord_t'(cols);
		kernel_sel = sel[`CONV_KSEL_W-1:0];
		expect_tile(rows, cols, sel);
		run = 1'b1;
		@(negedge clk);
		while (!tile_done)
			@(negedge clk);
		check_flag("reads_done", 1'b1, exp_col.size() == 0);
		while (exp_data.size() != 0)
			@(negedge clk);
		// done must hold while run stays up
		repeat (4)
		begin
			@(negedge clk);
			check_flag("tile_done", 1'b1, tile_done);
		end
		run = 1'b0;
		@(negedge clk);
		check_flag("tile_done", 1'b0, tile_done);
	endtask

	// memory models with read-order, latency and timeout checks
	always @(negedge clk)
	begin
		cycles++;
		if (cycles > limit)
		begin
			$display("timeout: no verdict after %0d cycles", limit);
			$display("errors: %0d", errors);
			$display("Simulation FAILED");
			$finish;
		end
		else
		begin
			if (rd_pend)
				for (int r = 0; r < 3; r++)
					in_rdata[r] = row_word(pend_row[r], pend_word);
			if (w_pend)
				w_rdata = tap_word(int'(pend_waddr));
			rd_pend = in_rd;
			pend_row = in_row;
			pend_word = in_word;
			w_pend = w_rd;
			pend_waddr = w_addr;
			if (in_rd)
			begin
				if (exp_col.size() == 0)
				begin
					$display("%0t: row read issued with no window left in the tile", $time);
					errors++;
				end
				else
				begin
					rd_col = exp_col.pop_front();
					exp_wd = (rd_col % 4 < 2) ? rd_col / 4 : rd_col / 4 + 1;
					check_word(word_addr_t'(exp_wd), in_word);
					rd_cycle.push_back(cycles);
				end
			end
			if (out_valid)
			begin
				if (exp_data.size() == 0 || rd_cycle.size() == 0)
				begin
					$display("%0t: result arrived with no window pending", $time);
					errors++;
				end
				else
				begin
					check_out_data(exp_data.pop_front(), out_data);
					check_out_addr(exp_addr.pop_front(), out_addr);
					rd_at = rd_cycle.pop_front();
					if (cycles - rd_at != LATENCY)
					begin
						$display("[FAIL] %0t latency: expected %0d got %0d",
							$time, LATENCY, cycles - rd_at);
						errors++;
					end
				end
			end
		end
	end

	initial
	begin
		rng_state = 32'h8939;
		errors = 0;
		cycles = 0;
		limit = 0;
		rst = 1'b1;
		run = 1'b0;
		map_rows = coord_t'(3);
		map_cols = coord_t'(3);
		kernel_sel = '0;
		for (int r = 0; r < 3; r++)
			in_rdata[r] = '0;
		w_rdata = '0;
		rd_pend = 1'b0;
		w_pend = 1'b0;
		for (int s = 0; s < (1 << `CONV_KSEL_W); s++)
			for (int i = 0; i < 9; i++)
				kern[s][i] = tap_t'(xorshift32());
		// every tile gets a different kernel than the one before
		for (int t = 0; t < NUM_TILES; t++)
		begin
			tile_rows[t] = 3 + xorshift32() % 14;
			tile_cols[t] = 3 + xorshift32() % 14;
			// first tile is the widest map so all four column phases occur
			if (t == 0)
				tile_cols[t] = `CONV_MAP_MAX;
			tile_ksel[t] = xorshift32() % (1 << `CONV_KSEL_W);
			if (t > 0 && tile_ksel[t] == tile_ksel[t-1])
				tile_ksel[t] = (tile_ksel[t] + 1) % (1 << `CONV_KSEL_W);
			limit += tile_rows[t] * tile_cols[t] + 20;
		end
		limit = 2 * limit;
		repeat (10) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_flag("tile_done", 1'b0, tile_done);
		check_flag("out_valid", 1'b0, out_valid);
		check_flag("in_rd", 1'b0, in_rd);
		check_flag("w_rd", 1'b0, w_rd);
		for (int t = 0; t < NUM_TILES; t++)
			run_tile(tile_rows[t], tile_cols[t], tile_ksel[t]);
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/conv_tile_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module conv_tile_top (
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input conv_pkg::coord_t map_rows,
	input conv_pkg::coord_t map_cols,
	input wire logic [`CONV_KSEL_W-1:0] kernel_sel,
	output logic in_rd,
	output conv_pkg::coord_t in_row [3],
	output conv_pkg::word_addr_t in_word,
	input conv_pkg::row_word_t in_rdata [3],
	output logic w_rd,
	output logic [`CONV_KSEL_W-1:0] w_addr,
	input conv_pkg::tap_word_t w_rdata,
	output logic out_valid,
	output conv_pkg::out_addr_t out_addr,
	output conv_pkg::acc_t out_data,
	output logic tile_done
);

	logic fetch;
	logic scan_valid;
	logic [1:0] col_phase;
	conv_pkg::coord_t row;
	conv_pkg::coord_t col;
	logic win_valid;
	conv_pkg::win_t win;
	conv_pkg::taps_t taps;

	tile_scanner scanner_i (
		.clk(clk),
		.rst(rst),
		.run(run),
		.map_rows(map_rows),
		.map_cols(map_cols),
		.fetch(fetch),
		.scan_valid(scan_valid),
		.in_rd(in_rd),
		.tile_done(tile_done),
		.row(row),
		.col(col),
		.col_phase(col_phase),
		.in_row(in_row),
		.in_word(in_word)
	);

	input_window input_i (
		.clk(clk),
		.rst(rst),
		.scan_valid(scan_valid),
		.col_phase(col_phase),
		.in_rdata(in_rdata),
		.win_valid(win_valid),
		.win(win)
	);

	weight_window weight_i (
		.clk(clk),
		.rst(rst),
		.fetch(fetch),
		.kernel_sel(kernel_sel),
		.w_rdata(w_rdata),
		.w_rd(w_rd),
		.w_addr(w_addr),
		.taps(taps)
	);

	window_mac mac_i (
		.clk(clk),
		.rst(rst),
		.scan_valid(scan_valid),
		.row(row),
		.col(col),
		.map_cols(map_cols),
		.win_valid(win_valid),
		.win(win),
		.taps(taps),
		.out_valid(out_valid),
		.out_addr(out_addr),
		.out_data(out_data)
	);

endmodule

`default_nettype wire

//--- rtl/window_mac.sv
`timescale 1ns/1ps
`default_nettype none

module window_mac (
	input wire logic clk,
	input wire logic rst,
	input wire logic scan_valid,
	input conv_pkg::coord_t row,
	input conv_pkg::coord_t col,
	input conv_pkg::coord_t map_cols,
	input wire logic win_valid,
	input conv_pkg::win_t win,
	input conv_pkg::taps_t taps,
	output logic out_valid,
	output conv_pkg::out_addr_t out_addr,
	output conv_pkg::acc_t out_data
);
	import conv_pkg::*;

	out_addr_t out_w;
	out_addr_t addr_c;
	out_addr_t addr_q1;
	out_addr_t addr_q2;
	acc_t sum;

	// output map is map_cols minus 2 wide
	assign out_w = out_addr_t'(map_cols) - out_addr_t'(2);
	assign addr_c = out_addr_t'(row) * out_w + out_addr_t'(col);

	// address follows the window through read and capture
	always_ff @(posedge clk)
	begin
		if (scan_valid)
			addr_q1 <= addr_c;
		addr_q2 <= addr_q1;
	end

	always_comb
	begin
		sum = '0;
		for (int i = 0; i < 9; i++)
			sum = sum + acc_t'(win[i]) * acc_t'(taps[i]);
	end

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			out_valid <= 1'b0;
		else
			out_valid <= win_valid;
	end

	always_ff @(posedge clk)
	begin
		if (win_valid)
		begin
			out_data <= sum;
			out_addr <= addr_q2;
		end
	end

endmodule

`default_nettype wire

//--- rtl/weight_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module weight_window (
	input wire logic clk,
	input wire logic rst,
	input wire logic fetch,
	input wire logic [`CONV_KSEL_W-1:0] kernel_sel,
	input conv_pkg::tap_word_t w_rdata,
	output logic w_rd,
	output logic [`CONV_KSEL_W-1:0] w_addr,
	output conv_pkg::taps_t taps
);
	import conv_pkg::*;

	logic w_rd_d;

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			w_rd <= 1'b0;
			w_rd_d <= 1'b0;
		end
		else
		begin
			w_rd <= fetch;
			w_rd_d <= w_rd;
		end
	end

	always_ff @(posedge clk)
	begin
		if (fetch)
			w_addr <= kernel_sel;
	end

	// tap 0 is the top slice, held until the next fetch
	always_ff @(posedge clk)
	begin
		if (w_rd_d)
			for (int i = 0; i < 9; i++)
				taps[i] <= tap_t'(w_rdata[(8-i)*`CONV_TAP_W +: `CONV_TAP_W]);
	end

endmodule

`default_nettype wire

//--- rtl/input_window.sv
`timescale 1ns/1ps
`default_nettype none

`include "conv_cfg.svh"

module input_window (
	input wire logic clk,
	input wire logic rst,
	input wire logic scan_valid,
	input wire logic [1:0] col_phase,
	input conv_pkg::row_word_t in_rdata [3],
	output logic win_valid,
	output conv_pkg::win_t win
);
	import conv_pkg::*;

	logic rd_valid;
	logic [1:0] rd_phase;

	function automatic pixel_t lane_of(input row_word_t w, input int k);
		return pixel_t'(w[k*`CONV_PIX_W +: `CONV_PIX_W]);
	endfunction

	// line the strobe and phase up with the returning row words
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			rd_valid <= 1'b0;
			rd_phase <= 2'd0;
			win_valid <= 1'b0;
		end
		else
		begin
			rd_valid <= scan_valid;
			rd_phase <= col_phase;
			win_valid <= rd_valid;
		end
	end

	// phases 0 and 1 load a full row slice from one word
	// phases 2 and 3 reuse the previous window and pull one new pixel
	always_ff @(posedge clk)
	begin
		if (rd_valid)
		begin
			for (int r = 0; r < 3; r++)
			begin
				if (!rd_phase[1])
				begin
					win[3*r] <= lane_of(in_rdata[r], 0 + rd_phase[0]);
					win[3*r+1] <= lane_of(in_rdata[r], 1 + rd_phase[0]);
					win[3*r+2] <= lane_of(in_rdata[r], 2 + rd_phase[0]);
				end
				else
				begin
					win[3*r] <= win[3*r+1];
					win[3*r+1] <= win[3*r+2];
					// lane 0 for phase 2, lane 1 for phase 3
					win[3*r+2] <= lane_of(in_rdata[r], rd_phase[0]);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/tile_scanner.sv
`timescale 1ns/1ps
`default_nettype none

module tile_scanner (
	input wire logic clk,
	input wire logic rst,
	input wire logic run,
	input conv_pkg::coord_t map_rows,
	input conv_pkg::coord_t map_cols,
	output logic fetch,
	output logic scan_valid,
	output logic in_rd,
	output logic tile_done,
	output conv_pkg::coord_t row,
	output conv_pkg::coord_t col,
	output logic [1:0] col_phase,
	output conv_pkg::coord_t in_row [3],
	output conv_pkg::word_addr_t in_word
);
	import conv_pkg::*;

	scan_state_t state;
	scan_state_t state_nxt;
	logic last_col;
	logic last_row;

	// last window origin is side minus 3
	assign last_col = (col == map_cols - coord_t'(3));
	assign last_row = (row == map_rows - coord_t'(3));

	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
			state <= IDLE;
		else
			state <= state_nxt;
	end

	always_comb
	begin
		state_nxt = state;
		case (state)
			IDLE:
				if (run)
					state_nxt = FETCH;
			FETCH:
				state_nxt = run ? SCAN : IDLE;
			SCAN:
			begin
				if (!run)
					state_nxt = IDLE;
				else if (last_col && last_row)
					state_nxt = DONE;
			end
			DONE:
				if (!run)
					state_nxt = IDLE;
			default:
				state_nxt = IDLE;
		endcase
	end

	// window walk, one origin per clock while scanning
	always_ff @(posedge clk, posedge rst)
	begin
		if (rst)
		begin
			row <= '0;
			col <= '0;
		end
		else if (state != SCAN)
		begin
			row <= '0;
			col <= '0;
		end
		else if (last_col)
		begin
			col <= '0;
			row <= row + coord_t'(1);
		end
		else
			col <= col + coord_t'(1);
	end

	assign fetch = (state == FETCH);
	assign scan_valid = (state == SCAN);
	assign in_rd = scan_valid;
	assign tile_done = (state == DONE);

	assign col_phase = col[1:0];

	// phases 2 and 3 need the next word, the rest is already held
	assign in_word = col[1] ? word_addr_t'(col[4:2]) + word_addr_t'(1) : word_addr_t'(col[4:2]);

	assign in_row[0] = row;
	assign in_row[1] = row + coord_t'(1);
	assign in_row[2] = row + coord_t'(2);

endmodule

`default_nettype wire

//--- rtl/conv_pkg.sv
`default_nettype none

`include "conv_cfg.svh"

package conv_pkg;

	typedef logic signed [`CONV_PIX_W-1:0] pixel_t;
	typedef logic signed [`CONV_TAP_W-1:0] tap_t;
	typedef logic signed [`CONV_ACC_W-1:0] acc_t;
	typedef logic [`CONV_COORD_W-1:0] coord_t;

	// lane 0 sits in the low bits
	typedef logic [`CONV_LANES*`CONV_PIX_W-1:0] row_word_t;

	// tap 0 sits in the high bits
	typedef logic [9*`CONV_TAP_W-1:0] tap_word_t;

	// row-major 3x3 window and its taps
	typedef pixel_t win_t [9];
	typedef tap_t taps_t [9];

	typedef logic [`CONV_WADDR_W-1:0] word_addr_t;
	typedef logic [7:0] out_addr_t;

	typedef enum logic [1:0] {IDLE, FETCH, SCAN, DONE} scan_state_t;

endpackage

`default_nettype wire

//--- include/conv_cfg.svh
`ifndef CONV_CFG_SVH
`define CONV_CFG_SVH

// pixel and weight word widths
`define CONV_PIX_W 16
`define CONV_TAP_W 16

// accumulator holds nine 32-bit products with headroom
`define CONV_ACC_W 40

// pixels packed into one row-memory word
`define CONV_LANES 4

// largest feature map side
`define CONV_MAP_MAX 16

// row and column index width, covers 0 to CONV_MAP_MAX
`define CONV_COORD_W 5

// word address within one row bank
`define CONV_WADDR_W 3

// kernel select, one weight word per kernel
`define CONV_KSEL_W 4

`endif
